// File: dramCtrlTop.f
logic/dramCtrlPkg.sv
logic/countdownTimer.sv
logic/accessSequencer.sv
logic/sdramPins.sv
logic/dramCtrlTop.sv
test/sdramModel.sv
test/dramCtrlTb.sv

// File: logic/accessSequencer.sv
// SDRAM access sequencer
// FSM that runs the power-up and init sequence, periodic refresh bursts and
// single-word reads and writes with auto-precharge, picking the SDRAM command,
// address, bank and the CPU handshake for the pin stage

`timescale 1ns/1ps
`default_nettype none

module accessSequencer (
	input  logic                     Clock,
	input  logic                     Reset_L,
	input  dramCtrlPkg::cpuAddr_t    address,
	input  dramCtrlPkg::dataWord_t   dataIn,
	input  logic                     UDS_L,
	input  logic                     LDS_L,
	input  logic                     DramSelect_L,
	input  logic                     WE_L,		// high for a read
	input  logic                     AS_L,
	input  dramCtrlPkg::timerCount_t timerCount,
	input  logic                     timerDone,
	input  logic                     refreshDue,	// refresh interval elapsed
	output logic                     timerLoad,
	output dramCtrlPkg::timerCount_t timerValue,
	output logic                     refreshLoad,
	output dramCtrlPkg::timerCount_t refreshValue,
	output dramCtrlPkg::sdramCmd_t   cmd,
	output dramCtrlPkg::rowAddr_t    sdAddr,
	output dramCtrlPkg::bankAddr_t   sdBank,
	output logic                     writeDrive,	// DQ driven next cycle
	output dramCtrlPkg::dataWord_t   writeData,
	output logic                     readCapture,	// latch DQ on this falling edge
	output logic                     cpuAck,		// Dtack to the CPU
	output logic                     cpuRun		// releases the CPU reset
);

	import dramCtrlPkg::*;

	seqState_t state;
	seqState_t nextState;
	logic      initDone;					// sticky, init sequence finished
	logic      accessStart;
	logic      strobeLow;

	assign accessStart = !AS_L && !DramSelect_L;
	assign strobeLow   = !UDS_L || !LDS_L;		// either strobe counts, no byte masking
	assign cpuRun      = initDone;

	//////////////////////////////
	// state register
	//////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state    <= InitLoad;
			initDone <= 1'b0;
		end else begin
			state <= nextState;
			if (state == ModeWait) begin
				initDone <= 1'b1;		// CPU may start two cycles after mode set
			end
		end
	end

	//////////////////////////////
	// next state and outputs
	//////////////////////////////

	always_comb begin
		nextState    = state;
		cmd          = CmdNop;
		sdAddr       = '0;
		sdBank       = '0;
		timerLoad    = 1'b0;
		timerValue   = '0;
		refreshLoad  = 1'b0;
		refreshValue = '0;
		writeDrive   = 1'b0;
		writeData    = dataIn;
		readCapture  = 1'b0;
		cpuAck       = 1'b0;

		case (state)
			InitLoad: begin
				cmd        = CmdPowerUp;
				timerLoad  = 1'b1;
				timerValue = PowerUpCycles;
				nextState  = PowerUpWait;
			end
			PowerUpWait: begin
				cmd = CmdPowerUp;			// CKE stays low for the whole wait
				if (timerDone) begin
					nextState = FirstNop;
				end
			end
			FirstNop: begin
				nextState = PrechargeAll;		// first valid command with CKE high
			end
			PrechargeAll: begin
				cmd                      = CmdPrechargeAll;
				sdAddr[AutoPrechargeBit] = 1'b1;	// all banks
				nextState                = PrechargeNop;
			end
			PrechargeNop: begin
				timerLoad  = 1'b1;
				timerValue = InitRefreshCycles;
				nextState  = InitRefresh;
			end
			InitRefresh: begin
				if (timerDone) begin
					// periodic bursts skip the mode register
					nextState = initDone ? RefreshArm : ModeSet;
				end else if ((timerCount % InitRefreshSpacing) == '0) begin
					cmd = CmdAutoRefresh;		// one in every four cycles
				end
			end
			ModeSet: begin
				cmd        = CmdModeSet;
				sdAddr     = ModeRegValue;
				timerLoad  = 1'b1;
				timerValue = ModeWaitCycles;
				nextState  = ModeWait;
			end
			ModeWait: begin
				if (timerDone) begin
					nextState = RefreshArm;
				end
			end
			RefreshArm: begin
				refreshLoad  = 1'b1;
				refreshValue = RefreshInterval;
				nextState    = Idle;
			end
			Idle: begin
				if (refreshDue) begin
					nextState = PrechargeAll;	// refresh beats a pending access
				end else if (accessStart) begin
					cmd       = CmdActivate;
					sdAddr    = address[RowMsb:RowLsb];
					sdBank    = address[BankMsb:BankLsb];
					nextState = WE_L ? ReadCmd : WriteWait;
				end
			end
			ReadCmd: begin
				cmd                      = CmdRead;
				sdAddr[ColMsb-ColLsb:0]  = address[ColMsb:ColLsb];
				sdAddr[AutoPrechargeBit] = 1'b1;
				sdBank                   = address[BankMsb:BankLsb];
				timerLoad                = 1'b1;
				timerValue               = CasWaitCycles;
				nextState                = CasWait;
			end
			CasWait: begin
				cpuAck = 1'b1;
				// data is on DQ CasLatency cycles after the read hits the pins
				readCapture = (timerCount == (CasWaitCycles - timerCount_t'(CasLatency)));
				if (timerDone) begin
					nextState = CycleEnd;
				end
			end
			WriteWait: begin
				if (strobeLow) begin
					cmd                      = CmdWrite;
					sdAddr[ColMsb-ColLsb:0]  = address[ColMsb:ColLsb];
					sdAddr[AutoPrechargeBit] = 1'b1;
					sdBank                   = address[BankMsb:BankLsb];
					writeDrive               = 1'b1;
					cpuAck                   = 1'b1;	// data taken with the command
					nextState                = WriteHold;
				end
			end
			WriteHold: begin
				writeDrive = 1'b1;			// one more cycle of DQ hold
				cpuAck     = 1'b1;
				nextState  = CycleEnd;
			end
			CycleEnd: begin
				if (strobeLow) begin
					cpuAck = 1'b1;			// CPU still in its bus cycle
				end else begin
					nextState = Idle;
				end
			end
			default: begin
				nextState = InitLoad;
			end
		endcase
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// no row opens before the CPU has been let out of reset
	assert property (@(posedge Clock) disable iff (!Reset_L)
		(cmd == CmdActivate) |-> cpuRun);

	// DQ is only ever driven from the write states
	assert property (@(posedge Clock) disable iff (!Reset_L)
		writeDrive |-> (state == WriteWait || state == WriteHold));

	// Dtack is always released before a new cycle can start
	assert property (@(posedge Clock) disable iff (!Reset_L)
		(state == Idle) |-> !cpuAck);

endmodule

`default_nettype wire

// File: logic/countdownTimer.sv
// Loadable down-counter
// loads on request, then counts down once per clock and parks at zero,
// with done high while the count sits at zero

`timescale 1ns/1ps
`default_nettype none

module countdownTimer (
	input  logic                     Clock,
	input  logic                     Reset_L,
	input  logic                     load,		// one-cycle load request
	input  dramCtrlPkg::timerCount_t loadValue,
	output dramCtrlPkg::timerCount_t count,
	output logic                     done		// count has reached zero
);

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			count <= '0;					// comes out of reset already expired
		end else if (load) begin
			count <= loadValue;				// load wins over counting
		end else if (!done) begin
			count <= count - 1'b1;
		end
	end

	assign done = (count == '0);				// stays high until the next load

	//////////////////////////////
	// checks
	//////////////////////////////

	// once expired the counter must hold zero until reloaded
	assert property (@(posedge Clock) disable iff (!Reset_L)
		(done && !load) |=> done);

	// without a load the count never goes up, so no wrap past zero
	assert property (@(posedge Clock) disable iff (!Reset_L)
		!load |=> (count <= $past(count)));

endmodule

`default_nettype wire

// File: logic/dramCtrlPkg.sv
// SDRAM controller shared definitions
// widths, SDRAM command codes, sequencer states, timing counts and the
// CPU address field positions for a 32M x 16 part at CAS latency 2

`default_nettype none

package dramCtrlPkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	typedef logic [31:0] cpuAddr_t;		// 68000 side address
	typedef logic [15:0] dataWord_t;	// one data word, CPU and DQ side
	typedef logic [12:0] rowAddr_t;		// SDRAM A12..A0, row or column + A10
	typedef logic [1:0]  bankAddr_t;	// BA1..BA0
	typedef logic [15:0] timerCount_t;	// both down-counters
	typedef logic [4:0]  sdramCmd_t;	// CKE, CS_L, RAS_L, CAS_L, WE_L

	//////////////////////////////
	// command codes
	//////////////////////////////

	localparam sdramCmd_t CmdPowerUp      = 5'b00000;	// CKE and CS low while power settles
	localparam sdramCmd_t CmdNop          = 5'b10111;
	localparam sdramCmd_t CmdPrechargeAll = 5'b10010;	// A10 high selects all banks
	localparam sdramCmd_t CmdAutoRefresh  = 5'b10001;
	localparam sdramCmd_t CmdModeSet      = 5'b10000;	// mode word on the address pins
	localparam sdramCmd_t CmdActivate     = 5'b10011;	// row open, bank + row on pins
	localparam sdramCmd_t CmdRead         = 5'b10101;	// always with A10 set, auto-precharge
	localparam sdramCmd_t CmdWrite        = 5'b10100;	// always with A10 set, auto-precharge

	//////////////////////////////
	// sequencer states
	//////////////////////////////

	typedef enum logic [3:0] {
		InitLoad,		// arm power-up timer
		PowerUpWait,
		FirstNop,
		PrechargeAll,		// shared by init and periodic refresh
		PrechargeNop,
		InitRefresh,		// burst of auto-refreshes
		ModeSet,
		ModeWait,
		RefreshArm,		// reload the refresh interval
		Idle,
		ReadCmd,		// activate-to-read
		WriteWait,		// row open, waiting for a data strobe
		WriteHold,
		CasWait,
		CycleEnd		// holds Dtack until strobes rise
	} seqState_t;

	//////////////////////////////
	// timing, shortened for simulation
	//////////////////////////////

	localparam timerCount_t PowerUpCycles      = 16'd8;
	localparam timerCount_t InitRefreshCycles  = 16'd40;	// ten refreshes at spacing 4
	localparam timerCount_t InitRefreshSpacing = 16'd4;
	localparam rowAddr_t    ModeRegValue       = 13'h220;	// CL 2, burst length 1
	localparam timerCount_t ModeWaitCycles     = 16'd3;
	localparam timerCount_t CasWaitCycles      = 16'd3;	// four CasWait cycles in all
	localparam timerCount_t RefreshInterval    = 16'd375;
	localparam int          CasLatency         = 2;

	// CPU address fields, word addressed so bit 0 is unused
	localparam int RowMsb           = 23;
	localparam int RowLsb           = 11;
	localparam int BankMsb          = 25;
	localparam int BankLsb          = 24;
	localparam int ColMsb           = 10;
	localparam int ColLsb           = 1;
	localparam int AutoPrechargeBit = 10;

endpackage

`default_nettype wire

// File: logic/dramCtrlTop.sv
// SDRAM controller top level
// 68000-style bus to a 32M x 16 SDRAM at CAS latency 2, built from the
// access sequencer, a general and a refresh down-counter and the pin stage

`timescale 1ns/1ps
`default_nettype none

module dramCtrlTop (
	input  logic                   Clock,
	input  logic                   Reset_L,
	input  dramCtrlPkg::cpuAddr_t  Address,
	input  dramCtrlPkg::dataWord_t DataIn,
	input  logic                   UDS_L,
	input  logic                   LDS_L,
	input  logic                   DramSelect_L,
	input  logic                   WE_L,
	input  logic                   AS_L,
	output dramCtrlPkg::dataWord_t DataOut,
	output logic                   Dtack_L,
	output logic                   ResetOut_L,
	output logic                   SDram_CKE_H,
	output logic                   SDram_CS_L,
	output logic                   SDram_RAS_L,
	output logic                   SDram_CAS_L,
	output logic                   SDram_WE_L,
	output dramCtrlPkg::rowAddr_t  SDram_Addr,
	output dramCtrlPkg::bankAddr_t SDram_BA,
	inout  wire dramCtrlPkg::dataWord_t SDram_DQ
);

	import dramCtrlPkg::*;

	wire              timerLoad;		// general timer
	wire timerCount_t timerValue;
	wire timerCount_t timerCount;
	wire              timerDone;
	wire              refreshLoad;		// refresh interval timer
	wire timerCount_t refreshValue;
	wire              refreshDue;
	wire sdramCmd_t   cmd;			// sequencer to pin stage
	wire rowAddr_t    sdAddr;
	wire bankAddr_t   sdBank;
	wire              writeDrive;
	wire dataWord_t   writeData;
	wire              readCapture;
	wire              cpuAck;
	wire              cpuRun;

	accessSequencer sequencer (
		.Clock, .Reset_L,
		.address(Address), .dataIn(DataIn),
		.UDS_L, .LDS_L, .DramSelect_L, .WE_L, .AS_L,
		.timerCount, .timerDone, .refreshDue,
		.timerLoad, .timerValue, .refreshLoad, .refreshValue,
		.cmd, .sdAddr, .sdBank, .writeDrive, .writeData,
		.readCapture, .cpuAck, .cpuRun
	);

	countdownTimer generalTimer (
		.Clock, .Reset_L,
		.load(timerLoad), .loadValue(timerValue),
		.count(timerCount), .done(timerDone)
	);

	// only the expiry of the refresh counter matters
	countdownTimer refreshTimer (
		.Clock, .Reset_L,
		.load(refreshLoad), .loadValue(refreshValue),
		.count(), .done(refreshDue)
	);

	sdramPins pins (
		.Clock, .Reset_L,
		.cmd, .sdAddr, .sdBank, .writeDrive, .writeData,
		.readCapture, .cpuAck, .cpuRun,
		.SDram_CKE_H, .SDram_CS_L, .SDram_RAS_L, .SDram_CAS_L, .SDram_WE_L,
		.SDram_Addr, .SDram_BA, .SDram_DQ,
		.DataOut, .Dtack_L, .ResetOut_L
	);

endmodule

`default_nettype wire

// File: logic/sdramPins.sv
// SDRAM and CPU pin stage
// registers command, address, bank and the CPU handshake one cycle behind
// the sequencer, drives write data onto DQ and latches read data on the
// falling edge for the CPU

`timescale 1ns/1ps
`default_nettype none

module sdramPins (
	input  logic                   Clock,
	input  logic                   Reset_L,
	input  dramCtrlPkg::sdramCmd_t cmd,
	input  dramCtrlPkg::rowAddr_t  sdAddr,
	input  dramCtrlPkg::bankAddr_t sdBank,
	input  logic                   writeDrive,
	input  dramCtrlPkg::dataWord_t writeData,
	input  logic                   readCapture,	// used unregistered on negedge
	input  logic                   cpuAck,
	input  logic                   cpuRun,
	output logic                   SDram_CKE_H,
	output logic                   SDram_CS_L,
	output logic                   SDram_RAS_L,
	output logic                   SDram_CAS_L,
	output logic                   SDram_WE_L,
	output dramCtrlPkg::rowAddr_t  SDram_Addr,
	output dramCtrlPkg::bankAddr_t SDram_BA,
	inout  wire dramCtrlPkg::dataWord_t SDram_DQ,
	output dramCtrlPkg::dataWord_t DataOut,
	output logic                   Dtack_L,
	output logic                   ResetOut_L
);

	import dramCtrlPkg::*;

	logic      dqDrive;					// registered DQ output enable
	dataWord_t dqData;					// registered write word

	//////////////////////////////
	// output registers
	//////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= CmdPowerUp;
			SDram_Addr <= '0;
			SDram_BA   <= '0;
			Dtack_L    <= 1'b1;			// no acknowledge
			ResetOut_L <= 1'b0;			// CPU held in reset
			dqDrive    <= 1'b0;			// DQ released
		end else begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= cmd;
			SDram_Addr <= sdAddr;
			SDram_BA   <= sdBank;
			Dtack_L    <= !cpuAck;
			ResetOut_L <= cpuRun;
			dqDrive    <= writeDrive;
		end
	end

	always_ff @(posedge Clock) begin
		dqData <= writeData;				// lines up with dqDrive
	end

	// tristate toward the SDRAM, released whenever the part may drive
	assign SDram_DQ = dqDrive ? dqData : 'z;

	//////////////////////////////
	// read capture
	//////////////////////////////

	// middle of the data eye, held for the CPU until the next read
	always_ff @(negedge Clock) begin
		if (readCapture) begin
			DataOut <= SDram_DQ;
		end
	end

	// never drive DQ while a read is being captured
	assert property (@(negedge Clock) disable iff (!Reset_L)
		readCapture |-> !dqDrive);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the SDRAM controller testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module dramCtrlTb -f dramCtrlTop.f -o dramCtrlSim \
	&& ./obj_dir/dramCtrlSim | tee /dev/stderr | grep -q "Verification passed" \
	&& exit 0 \
	|| exit 1

// File: test/dramCtrlTb.sv
// SDRAM controller testbench
// drives the 68000-style bus on the falling edge through directed tests for
// init order, write and read back, address mapping, periodic refresh, strobe
// hold and an unselected cycle, against a behavioral SDRAM

`timescale 1ns/1ps
`default_nettype none

module dramCtrlTb;

	import dramCtrlPkg::*;

	localparam int ClockPeriod  = 4;
	localparam int InitLimit    = int'(PowerUpCycles) + int'(InitRefreshCycles) + 30;
	localparam int AckLimit     = int'(InitRefreshCycles) + 30;	// covers a refresh burst
	localparam int ReleaseLimit = 4;
	localparam int BurstCycles  = int'(InitRefreshCycles) + 10;
	localparam int IdleWindow   = 3 * (int'(RefreshInterval) + BurstCycles) + BurstCycles;
	localparam int AccessCount  = 16;
	localparam int RunLimit     = InitLimit + IdleWindow + AccessCount * (AckLimit + 12) + 100;

	logic      Clock = 1'b0;
	logic      Reset_L;
	cpuAddr_t  Address;
	dataWord_t DataIn;
	logic      UDS_L;
	logic      LDS_L;
	logic      DramSelect_L;
	logic      WE_L;
	logic      AS_L;
	dataWord_t DataOut;
	logic      Dtack_L;
	logic      ResetOut_L;
	logic      SDram_CKE_H;
	logic      SDram_CS_L;
	logic      SDram_RAS_L;
	logic      SDram_CAS_L;
	logic      SDram_WE_L;
	rowAddr_t  SDram_Addr;
	bankAddr_t SDram_BA;
	wire dataWord_t SDram_DQ;

	int          errorCount = 0;
	int          testCount = 0;
	int          failCount = 0;
	logic [31:0] rngState = 32'haf4a;

	always #(ClockPeriod / 2) Clock = ~Clock;

	dramCtrlTop uut (.*);

	sdramModel memory (
		.Clock, .SDram_CKE_H, .SDram_CS_L, .SDram_RAS_L, .SDram_CAS_L, .SDram_WE_L,
		.SDram_Addr, .SDram_BA, .SDram_DQ
	);

	//////////////////////////////
	// helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		errorCount++;
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("%s: ok", name);
		end else begin
			failCount++;
			$display("%s: FAILED with %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n) @(negedge Clock);
	endtask

	//////////////////////////////
	// CPU bus cycles
	//////////////////////////////

	task automatic startCycle(input cpuAddr_t addr, input logic isWrite, input dataWord_t data);
		@(negedge Clock);
		Address      = addr;
		DataIn       = data;
		WE_L         = !isWrite;
		AS_L         = 1'b0;
		DramSelect_L = 1'b0;
		UDS_L        = 1'b0;			// both strobes, word access
		LDS_L        = 1'b0;
	endtask

	task automatic waitAck(output logic acked);
		int waited;
		waited = 0;
		acked  = 1'b0;
		while (!acked && waited < AckLimit) begin
			@(negedge Clock);
			waited++;
			acked = (Dtack_L == 1'b0);
		end
		if (!acked) begin
			$display("no Dtack from the controller within %0d cycles", AckLimit);
			errorCount++;
		end
	endtask

	task automatic endCycle();
		int waited;
		@(negedge Clock);
		AS_L         = 1'b1;
		DramSelect_L = 1'b1;
		UDS_L        = 1'b1;
		LDS_L        = 1'b1;
		WE_L         = 1'b1;
		waited       = 0;
		while (Dtack_L !== 1'b1 && waited < ReleaseLimit) begin
			@(negedge Clock);
			waited++;
		end
		if (Dtack_L !== 1'b1) begin
			$display("Dtack stayed low after the strobes rose");
			errorCount++;
		end
	endtask

	task automatic cpuWrite(input cpuAddr_t addr, input dataWord_t data);
		logic acked;
		startCycle(addr, 1'b1, data);
		waitAck(acked);
		endCycle();
	endtask

	// holdCycles keeps the strobes low past the data sample
	task automatic cpuRead(input cpuAddr_t addr, output dataWord_t data, input int holdCycles);
		logic acked;
		startCycle(addr, 1'b0, '0);
		waitAck(acked);
		data = 'x;
		if (acked) begin
			repeat (3) @(negedge Clock);		// DataOut valid by now
			data = DataOut;
			repeat (holdCycles) begin
				@(negedge Clock);
				if (Dtack_L !== 1'b0) begin
					$display("Dtack released while the strobes were still low");
					errorCount++;
				end
			end
		end
		endCycle();
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic checkInitOrder();
		int errorsBefore;
		int waited;
		int dtackLow;
		int i;
		errorsBefore = errorCount;
		waited       = 0;
		dtackLow     = 0;
		while (ResetOut_L !== 1'b1 && waited < InitLimit) begin
			@(negedge Clock);
			waited++;
			if (Dtack_L !== 1'b1) dtackLow++;
		end
		if (ResetOut_L !== 1'b1) begin
			$display("ResetOut_L never rose after %0d cycles", InitLimit);
			errorCount++;
		end
		if (dtackLow != 0) begin
			$display("Dtack was low for %0d cycles during initialisation", dtackLow);
			errorCount++;
		end
		if (memory.cmdLog.size() != 12) begin
			mismatch("initOrder command count", 32'd12, 32'(memory.cmdLog.size()));
		end else begin
			if (memory.cmdLog[0] !== CmdPrechargeAll)
				mismatch("initOrder precharge", 32'(CmdPrechargeAll), 32'(memory.cmdLog[0]));
			if (memory.addrLog[0][AutoPrechargeBit] !== 1'b1)
				mismatch("initOrder A10", 32'd1, 32'(memory.addrLog[0][AutoPrechargeBit]));
			for (i = 1; i <= 10; i++) begin
				if (memory.cmdLog[i] !== CmdAutoRefresh)
					mismatch("initOrder refresh", 32'(CmdAutoRefresh), 32'(memory.cmdLog[i]));
			end
			if (memory.cmdLog[11] !== CmdModeSet)
				mismatch("initOrder mode set", 32'(CmdModeSet), 32'(memory.cmdLog[11]));
			if (memory.addrLog[11] !== ModeRegValue)
				mismatch("initOrder mode word", 32'(ModeRegValue), 32'(memory.addrLog[11]));
		end
		finishTest("initOrder", errorsBefore);
	endtask

	task automatic writeReadBack();
		int        errorsBefore;
		dataWord_t word;
		errorsBefore = errorCount;
		cpuWrite(32'h0012_3456, 16'h5a3c);
		cpuRead(32'h0012_3456, word, 0);
		if (word !== 16'h5a3c) mismatch("writeReadBack", 32'h5a3c, 32'(word));
		finishTest("writeReadBack", errorsBefore);
	endtask

	task automatic addressMapping();
		int        errorsBefore;
		int        i;
		cpuAddr_t  addrs [4];
		dataWord_t words [4];
		dataWord_t word;
		errorsBefore = errorCount;
		for (i = 0; i < 4; i++) begin
			rngState = xorshift(rngState);
			addrs[i] = '0;
			addrs[i][BankMsb:BankLsb] = bankAddr_t'(i);	// one word per bank
			addrs[i][RowMsb:RowLsb]   = rngState[12:0];
			addrs[i][ColMsb:ColLsb]   = rngState[25:16];
			rngState = xorshift(rngState);
			words[i] = rngState[15:0];
			cpuWrite(addrs[i], words[i]);
			if (memory.lastBank !== addrs[i][BankMsb:BankLsb])
				mismatch("addressMapping bank", 32'(addrs[i][BankMsb:BankLsb]),
					32'(memory.lastBank));
			if (memory.lastRow !== addrs[i][RowMsb:RowLsb])
				mismatch("addressMapping row", 32'(addrs[i][RowMsb:RowLsb]),
					32'(memory.lastRow));
			if (memory.lastCol !== addrs[i][ColMsb:ColLsb])
				mismatch("addressMapping column", 32'(addrs[i][ColMsb:ColLsb]),
					32'(memory.lastCol));
			if (memory.lastAutoPre !== 1'b1)
				mismatch("addressMapping auto-precharge", 32'd1, 32'(memory.lastAutoPre));
		end
		for (i = 0; i < 4; i++) begin
			cpuRead(addrs[i], word, 0);
			if (word !== words[i]) mismatch("addressMapping data", 32'(words[i]), 32'(word));
		end
		finishTest("addressMapping", errorsBefore);
	endtask

	task automatic periodicRefresh();
		int        errorsBefore;
		int        refreshBefore;
		int        refreshSeen;
		dataWord_t word;
		errorsBefore  = errorCount;
		refreshBefore = memory.refreshCount;
		cpuWrite(32'h0234_5678, 16'hc3a5);
		idleCycles(IdleWindow / 2);
		cpuRead(32'h0234_5678, word, 0);		// lands between refresh bursts or inside one
		if (word !== 16'hc3a5) mismatch("periodicRefresh data", 32'hc3a5, 32'(word));
		idleCycles(IdleWindow - IdleWindow / 2);
		refreshSeen = memory.refreshCount - refreshBefore;
		if (refreshSeen < 30) begin
			$display("ERROR periodicRefresh: expected at least %0d, actual %0d", 30, refreshSeen);
			errorCount++;
		end
		finishTest("periodicRefresh", errorsBefore);
	endtask

	task automatic strobeHold();
		int        errorsBefore;
		dataWord_t word;
		logic      acked;
		errorsBefore = errorCount;
		cpuWrite(32'h0300_0aa4, 16'h1e0f);
		cpuRead(32'h0300_0aa4, word, 6);
		if (word !== 16'h1e0f) mismatch("strobeHold", 32'h1e0f, 32'(word));
		startCycle(32'h0300_0aa4, 1'b0, '0);
		waitAck(acked);
		@(negedge Clock);
		UDS_L = 1'b1;				// lower strobe alone keeps the cycle open
		repeat (4) begin
			@(negedge Clock);
			if (Dtack_L !== 1'b0) mismatch("strobeHold one strobe", 32'd0, 32'(Dtack_L));
		end
		endCycle();
		finishTest("strobeHold", errorsBefore);
	endtask

	task automatic noSelect();
		int errorsBefore;
		int activateBefore;
		errorsBefore   = errorCount;
		activateBefore = memory.activateCount;
		@(negedge Clock);
		Address      = 32'h0100_0200;
		WE_L         = 1'b1;
		AS_L         = 1'b0;
		DramSelect_L = 1'b1;			// some other device on the bus
		UDS_L        = 1'b0;
		LDS_L        = 1'b0;
		repeat (20) begin
			@(negedge Clock);
			if (Dtack_L !== 1'b1) mismatch("noSelect Dtack", 32'd1, 32'(Dtack_L));
		end
		AS_L  = 1'b1;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		if (memory.activateCount != activateBefore)
			mismatch("noSelect activates", 32'(activateBefore), 32'(memory.activateCount));
		finishTest("noSelect", errorsBefore);
	endtask

	//////////////////////////////
	// run and watchdog
	//////////////////////////////

	initial begin
		Reset_L      = 1'b0;
		Address      = '0;
		DataIn       = '0;
		UDS_L        = 1'b1;
		LDS_L        = 1'b1;
		DramSelect_L = 1'b1;
		WE_L         = 1'b1;
		AS_L         = 1'b1;
		repeat (2) @(negedge Clock);
		Reset_L = 1'b1;
		checkInitOrder();
		writeReadBack();
		addressMapping();
		periodicRefresh();
		strobeHold();
		noSelect();
		$display("%0d tests run, %0d failed, %0d errors", testCount, failCount, errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(RunLimit * ClockPeriod);
		$display("watchdog: run did not finish within %0d cycles", RunLimit);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/sdramModel.sv
// Behavioral SDRAM for the controller testbench
// decodes the command pins on the rising edge, keeps one open row per bank,
// stores written words and drives read data CasLatency cycles after a read,
// and counts and logs the commands it sees

`timescale 1ns/1ps
`default_nettype none

module sdramModel (
	input  logic                   Clock,
	input  logic                   SDram_CKE_H,
	input  logic                   SDram_CS_L,
	input  logic                   SDram_RAS_L,
	input  logic                   SDram_CAS_L,
	input  logic                   SDram_WE_L,
	input  dramCtrlPkg::rowAddr_t  SDram_Addr,
	input  dramCtrlPkg::bankAddr_t SDram_BA,
	inout  wire dramCtrlPkg::dataWord_t SDram_DQ
);

	import dramCtrlPkg::*;

	sdramCmd_t             pinCmd;
	rowAddr_t              openRow [4];			// row per bank
	dataWord_t             mem [logic [24:0]];		// bank, row, column
	logic [24:0]           key;
	logic [CasLatency-1:0] readPipe = '0;			// read in flight
	dataWord_t             readWord = '0;
	sdramCmd_t             cmdLog [$];			// every command except NOP and power-up
	rowAddr_t              addrLog [$];
	int                    refreshCount = 0;
	int                    activateCount = 0;
	bankAddr_t             lastBank = '0;			// last activate
	rowAddr_t              lastRow = '0;
	logic [9:0]            lastCol = '0;			// last read or write
	logic                  lastAutoPre = 1'b0;

	assign pinCmd = {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L};

	// output valid from one edge after the command edge up to the capture edge
	assign SDram_DQ = readPipe[CasLatency-1] ? readWord : 'z;

	always @(posedge Clock) begin
		readPipe <= {readPipe[CasLatency-2:0], (pinCmd == CmdRead)};
		key = {SDram_BA, openRow[SDram_BA], SDram_Addr[9:0]};
		case (pinCmd)
			CmdActivate: begin
				openRow[SDram_BA] <= SDram_Addr;
				lastBank          <= SDram_BA;
				lastRow           <= SDram_Addr;
				activateCount     <= activateCount + 1;
			end
			CmdRead: begin
				readWord    <= mem.exists(key) ? mem[key] : '0;	// unwritten reads as zero
				lastCol     <= SDram_Addr[9:0];
				lastAutoPre <= SDram_Addr[AutoPrechargeBit];
			end
			CmdWrite: begin
				mem[key] = SDram_DQ;		// controller drives DQ with the command
				lastCol     <= SDram_Addr[9:0];
				lastAutoPre <= SDram_Addr[AutoPrechargeBit];
			end
			CmdAutoRefresh: begin
				refreshCount <= refreshCount + 1;
			end
			default: begin
			end
		endcase
		if (pinCmd != CmdNop && pinCmd != CmdPowerUp) begin
			cmdLog.push_back(pinCmd);
			addrLog.push_back(SDram_Addr);
		end
	end

endmodule

`default_nettype wire
